//--- frv_pkg.sv
// Machine-control package
// Holds the timer MMIO window, CSR addresses, interrupt cause codes
// and the CSR address view shared by the CSR file
`default_nettype none

package frv_pkg;

  // --------------------------------------------------
  // Timer MMIO window
  // --------------------------------------------------
  localparam logic [31:0] MMIO_BASE_ADDR = 32'h0000_1000; // Window base
  localparam logic [31:0] MMIO_BASE_MASK = 32'hFFFF_F000; // Window select mask

  localparam logic [31:0] MTIME_LO    = 32'h0; // mtime bits 31:0
  localparam logic [31:0] MTIME_HI    = 32'h4; // mtime bits 63:32
  localparam logic [31:0] MTIMECMP_LO = 32'h8; // mtimecmp bits 31:0
  localparam logic [31:0] MTIMECMP_HI = 32'hC; // mtimecmp bits 63:32

  // Implementation id seen through mimpid
  localparam logic [31:0] CSR_MIMPID = 32'h0000_0001;

  // --------------------------------------------------
  // CSR addresses
  // --------------------------------------------------
  localparam logic [11:0] CSR_MSTATUS       = 12'h300; // Global enable lives here
  localparam logic [11:0] CSR_MIE           = 12'h304; // Per-source enables
  localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320; // Counter stop bits
  localparam logic [11:0] CSR_MIP           = 12'h344; // Pending bits
  localparam logic [11:0] CSR_CYCLE         = 12'hC00;
  localparam logic [11:0] CSR_CYCLEH        = 12'hC80;
  localparam logic [11:0] CSR_TIME          = 12'hC01;
  localparam logic [11:0] CSR_TIMEH         = 12'hC81;
  localparam logic [11:0] CSR_INSTRET       = 12'hC02;
  localparam logic [11:0] CSR_INSTRETH      = 12'hC82;
  localparam logic [11:0] CSR_MIMPID_ADDR   = 12'hF13; // Read-only id

  // --------------------------------------------------
  // Interrupt cause codes
  // --------------------------------------------------
  localparam logic [5:0] CAUSE_NMI      = 6'd0;  // Non-maskable
  localparam logic [5:0] CAUSE_MSI      = 6'd3;  // Machine software
  localparam logic [5:0] CAUSE_MTI      = 6'd7;  // Machine timer
  localparam logic [5:0] CAUSE_MEI_BASE = 6'd16; // Plus external cause code

  // Access field value of a read-only CSR
  localparam logic [1:0] CSR_ACCESS_RO = 2'b11;

  // Field split of a CSR address, from the top bits down
  typedef struct packed {
    logic [1:0] access;    // 2'b11 is read-only
    logic [1:0] privilege; // Lowest privilege allowed
    logic [7:0] index;     // Register number in the group
  } csr_addr_fields_t;

  // Same 12 bits seen raw or split into fields
  typedef union packed {
    logic [11:0]      raw;
    csr_addr_fields_t f;
  } csr_addr_u;

endpackage

`default_nettype wire

//--- frv_ifs.sv
// Machine-control links
// Counter values and inhibit bits between counters and CSR file, and the
// enable and pending bits between CSR file and interrupt block
`default_nettype none

interface frv_ctr_if;
  logic [63:0] ctr_cycle;   // Cycle counter
  logic [63:0] ctr_time;    // mtime
  logic [63:0] ctr_instret; // Retired instruction count
  logic        inhibit_cy;  // Hold cycle
  logic        inhibit_tm;  // Hold mtime
  logic        inhibit_ir;  // Hold instret

  modport ctr_src (
    output ctr_cycle, ctr_time, ctr_instret,
    input  inhibit_cy, inhibit_tm, inhibit_ir
  );

  modport ctr_snk (
    input  ctr_cycle, ctr_time, ctr_instret,
    output inhibit_cy, inhibit_tm, inhibit_ir
  );
endinterface

interface frv_irq_if;
  logic mstatus_mie; // Global enable
  logic mie_meie;    // External enable
  logic mie_mtie;    // Timer enable
  logic mie_msie;    // Software enable
  logic mip_meip;    // External pending
  logic mip_mtip;    // Timer pending
  logic mip_msip;    // Software pending

  modport irq_ctl (
    output mstatus_mie, mie_meie, mie_mtie, mie_msie,
    input  mip_meip, mip_mtip, mip_msip
  );

  modport irq_src (
    input  mstatus_mie, mie_meie, mie_mtie, mie_msie,
    output mip_meip, mip_mtip, mip_msip
  );
endinterface

`default_nettype wire

//--- frv_counters.sv
// Performance counters and machine timer
// Cycle, instret and mtime counters, mtimecmp, and the timer MMIO window
// with a single-cycle registered response
`default_nettype none

module frv_counters import frv_pkg::*; (
  input  wire logic        g_clk,      // Global clock
  input  wire logic        arst_n,     // Async reset, active low
  input  wire logic        instr_ret,  // Instruction retired
  frv_ctr_if.ctr_src       ctr,        // Counter values and inhibits
  output      logic        ti_pending, // mtime has reached mtimecmp
  input  wire logic        mmio_en,    // MMIO access
  input  wire logic        mmio_wen,   // MMIO write
  input  wire logic [31:0] mmio_addr,  // MMIO address
  input  wire logic [31:0] mmio_wdata, // MMIO write data
  output      logic [31:0] mmio_rdata, // Read data, one cycle later
  output      logic        mmio_error  // Bad access, one cycle later
);

  logic [63:0] mtimecmp;   // Timer compare value
  logic [31:0] offset;     // Address within window
  logic        in_window;  // Address hits the window
  logic        offset_ok;  // One of the four registers
  logic        mmio_bad;   // Access to be flagged
  logic        wr_ok;      // Accepted write
  logic [31:0] rdata_nxt;  // Read mux output

  // --------------------------------------------------
  // MMIO decode
  // --------------------------------------------------
  assign in_window = (mmio_addr & MMIO_BASE_MASK) == MMIO_BASE_ADDR;
  assign offset    = mmio_addr & ~MMIO_BASE_MASK;
  assign offset_ok = offset == MTIME_LO || offset == MTIME_HI ||
                     offset == MTIMECMP_LO || offset == MTIMECMP_HI;
  assign mmio_bad  = mmio_en && !(in_window && offset_ok);
  assign wr_ok     = mmio_en && mmio_wen && !mmio_bad;

  always_comb begin
    case (offset)
      MTIME_LO:    rdata_nxt = ctr.ctr_time[31:0];
      MTIME_HI:    rdata_nxt = ctr.ctr_time[63:32];
      MTIMECMP_LO: rdata_nxt = mtimecmp[31:0];
      MTIMECMP_HI: rdata_nxt = mtimecmp[63:32];
      default:     rdata_nxt = '0; // Flagged as error anyway
    endcase
  end

  // Timer line, purely combinational
  assign ti_pending = ctr.ctr_time >= mtimecmp;

  // --------------------------------------------------
  // Counters
  // --------------------------------------------------
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctr.ctr_cycle   <= '0;
      ctr.ctr_instret <= '0;
      ctr.ctr_time    <= '0;
      mtimecmp        <= '1; // No timer interrupt out of reset
    end else begin
      if (!ctr.inhibit_cy)
        ctr.ctr_cycle <= ctr.ctr_cycle + 64'd1;
      if (instr_ret && !ctr.inhibit_ir)
        ctr.ctr_instret <= ctr.ctr_instret + 64'd1;
      // A software write to mtime overrides the tick
      if (wr_ok && offset == MTIME_LO)
        ctr.ctr_time <= {ctr.ctr_time[63:32], mmio_wdata};
      else if (wr_ok && offset == MTIME_HI)
        ctr.ctr_time <= {mmio_wdata, ctr.ctr_time[31:0]};
      else if (!ctr.inhibit_tm)
        ctr.ctr_time <= ctr.ctr_time + 64'd1;
      if (wr_ok && offset == MTIMECMP_LO)
        mtimecmp[31:0] <= mmio_wdata;
      if (wr_ok && offset == MTIMECMP_HI)
        mtimecmp[63:32] <= mmio_wdata;
    end
  end

  // Response registers
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n)
      mmio_error <= 1'b0;
    else
      mmio_error <= mmio_bad;
  end

  always_ff @(posedge g_clk) begin
    if (mmio_en)
      mmio_rdata <= rdata_nxt; // Held between accesses
  end

  // Error response only ever answers an access
  a_mmio_err_follows_en: assert property (
    @(posedge g_clk) disable iff (!arst_n) mmio_error |-> $past(mmio_en));

endmodule

`default_nettype wire

//--- frv_interrupt.sv
// Interrupt controller
// Registers the pending lines, latches NMI edges, picks the highest
// priority eligible source and runs the trap request/acknowledge handshake
`default_nettype none

module frv_interrupt import frv_pkg::*; (
  input  wire logic       g_clk,          // Global clock
  input  wire logic       arst_n,         // Async reset, active low
  frv_irq_if.irq_src      irq,            // Enables in, pending bits out
  input  wire logic       ti_pending,     // Timer compare hit
  input  wire logic       nmi_pending,    // NMI line
  input  wire logic       ex_pending,     // External line
  input  wire logic       sw_pending,     // Software line
  input  wire logic [3:0] ex_cause,       // External cause code
  output      logic       int_trap_req,   // Trap request
  output      logic [5:0] int_trap_cause, // Cause of requested trap
  input  wire logic       int_trap_ack    // Trap taken
);

  logic       nmi_q;      // NMI line last cycle
  logic       nmi_latch;  // NMI seen, not yet taken
  logic       nmi_taken;  // NMI trap acknowledged now
  logic       eligible;   // Some source may trap
  logic [5:0] cause_nxt;  // Winning cause

  assign nmi_taken = int_trap_req && int_trap_ack && int_trap_cause == CAUSE_NMI;

  // --------------------------------------------------
  // Pending bits and NMI latch
  // --------------------------------------------------
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      irq.mip_meip <= 1'b0;
      irq.mip_mtip <= 1'b0;
      irq.mip_msip <= 1'b0;
      nmi_q        <= 1'b0;
      nmi_latch    <= 1'b0;
    end else begin
      irq.mip_meip <= ex_pending;
      irq.mip_mtip <= ti_pending;
      irq.mip_msip <= sw_pending;
      nmi_q        <= nmi_pending;
      if (nmi_pending && !nmi_q)
        nmi_latch <= 1'b1; // New edge wins over a clear
      else if (nmi_taken)
        nmi_latch <= 1'b0;
    end
  end

  // Priority, NMI ignores every enable
  always_comb begin
    eligible  = 1'b1;
    cause_nxt = CAUSE_NMI;
    if (nmi_latch)
      cause_nxt = CAUSE_NMI;
    else if (irq.mstatus_mie && irq.mie_meie && irq.mip_meip)
      cause_nxt = CAUSE_MEI_BASE + {2'b00, ex_cause};
    else if (irq.mstatus_mie && irq.mie_msie && irq.mip_msip)
      cause_nxt = CAUSE_MSI;
    else if (irq.mstatus_mie && irq.mie_mtie && irq.mip_mtip)
      cause_nxt = CAUSE_MTI;
    else
      eligible = 1'b0;
  end

  // --------------------------------------------------
  // Request/acknowledge
  // --------------------------------------------------
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      int_trap_req   <= 1'b0;
      int_trap_cause <= CAUSE_NMI;
    end else if (int_trap_req) begin
      if (int_trap_ack)
        int_trap_req <= 1'b0; // One idle cycle before next request
    end else if (eligible) begin
      int_trap_req   <= 1'b1;
      int_trap_cause <= cause_nxt;
    end
  end

  // Request and cause frozen until taken
  a_trap_hold: assert property (
    @(posedge g_clk) disable iff (!arst_n)
    int_trap_req && !int_trap_ack |=> int_trap_req && $stable(int_trap_cause));

endmodule

`default_nettype wire

//--- frv_csr_file.sv
// Machine CSR file
// Owns mstatus.MIE, mie and mcountinhibit, and serves reads of those, mip,
// the counters and mimpid with a registered single-cycle response
`default_nettype none

module frv_csr_file import frv_pkg::*; (
  input  wire logic        g_clk,     // Global clock
  input  wire logic        arst_n,    // Async reset, active low
  input  wire logic        csr_en,    // CSR access
  input  wire logic        csr_wen,   // CSR write
  input  wire logic [11:0] csr_addr,  // CSR address
  input  wire logic [31:0] csr_wdata, // Write data
  output      logic [31:0] csr_rdata, // Read data, one cycle later
  output      logic        csr_error, // Bad access, one cycle later
  frv_ctr_if.ctr_snk       ctr,       // Counters and inhibits
  frv_irq_if.irq_ctl       irq        // Enables and pending bits
);

  csr_addr_u   addr;      // Raw and field views
  logic        unknown;   // No such CSR
  logic        ro_write;  // Write to a read-only CSR
  logic        err_nxt;   // Access to be flagged
  logic        wr_ok;     // Accepted write
  logic [31:0] rdata_nxt; // Read mux output

  logic        mstatus_mie;
  logic        mie_meie, mie_mtie, mie_msie;
  logic        inh_cy, inh_tm, inh_ir;

  assign addr.raw = csr_addr;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    unknown   = 1'b0;
    rdata_nxt = '0;
    case (addr.raw)
      CSR_MSTATUS:       rdata_nxt[3] = mstatus_mie;
      CSR_MIE: begin
        rdata_nxt[11] = mie_meie;
        rdata_nxt[7]  = mie_mtie;
        rdata_nxt[3]  = mie_msie;
      end
      CSR_MCOUNTINHIBIT: rdata_nxt[2:0] = {inh_ir, inh_tm, inh_cy};
      CSR_MIP: begin
        rdata_nxt[11] = irq.mip_meip;
        rdata_nxt[7]  = irq.mip_mtip;
        rdata_nxt[3]  = irq.mip_msip;
      end
      CSR_CYCLE:         rdata_nxt = ctr.ctr_cycle[31:0];
      CSR_CYCLEH:        rdata_nxt = ctr.ctr_cycle[63:32];
      CSR_TIME:          rdata_nxt = ctr.ctr_time[31:0];
      CSR_TIMEH:         rdata_nxt = ctr.ctr_time[63:32];
      CSR_INSTRET:       rdata_nxt = ctr.ctr_instret[31:0];
      CSR_INSTRETH:      rdata_nxt = ctr.ctr_instret[63:32];
      CSR_MIMPID_ADDR:   rdata_nxt = CSR_MIMPID;
      default:           unknown = 1'b1;
    endcase
  end

  // Read-only by address encoding
  assign ro_write = csr_wen && addr.f.access == CSR_ACCESS_RO;
  assign err_nxt  = csr_en && (unknown || ro_write);
  assign wr_ok    = csr_en && csr_wen && !err_nxt;

  // --------------------------------------------------
  // Control registers
  // --------------------------------------------------
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      mstatus_mie <= 1'b0;
      mie_meie    <= 1'b0;
      mie_mtie    <= 1'b0;
      mie_msie    <= 1'b0;
      inh_cy      <= 1'b0;
      inh_tm      <= 1'b0;
      inh_ir      <= 1'b0;
      csr_error   <= 1'b0;
    end else begin
      csr_error <= err_nxt;
      if (wr_ok && addr.raw == CSR_MSTATUS)
        mstatus_mie <= csr_wdata[3];
      if (wr_ok && addr.raw == CSR_MIE) begin
        mie_meie <= csr_wdata[11];
        mie_mtie <= csr_wdata[7];
        mie_msie <= csr_wdata[3];
      end
      if (wr_ok && addr.raw == CSR_MCOUNTINHIBIT)
        {inh_ir, inh_tm, inh_cy} <= csr_wdata[2:0];
    end
  end

  always_ff @(posedge g_clk) begin
    if (csr_en)
      csr_rdata <= rdata_nxt; // Pre-write value on a write
  end

  assign irq.mstatus_mie = mstatus_mie;
  assign irq.mie_meie    = mie_meie;
  assign irq.mie_mtie    = mie_mtie;
  assign irq.mie_msie    = mie_msie;
  assign ctr.inhibit_cy  = inh_cy;
  assign ctr.inhibit_tm  = inh_tm;
  assign ctr.inhibit_ir  = inh_ir;

  // Error response only ever answers an access
  a_csr_err_follows_en: assert property (
    @(posedge g_clk) disable iff (!arst_n) csr_error |-> $past(csr_en));

endmodule

`default_nettype wire

//--- frv_machine_ctl.sv
// Machine-control top level
// CSR file, counters and interrupt controller wired to plain ports that
// stand in for the pipeline
`default_nettype none

module frv_machine_ctl (
  input  wire logic        g_clk,            // Global clock
  input  wire logic        arst_n,           // Async reset, active low
  // CSR access port
  input  wire logic        csr_en,           // CSR access
  input  wire logic        csr_wen,          // CSR write
  input  wire logic [11:0] csr_addr,         // CSR address
  input  wire logic [31:0] csr_wdata,        // CSR write data
  output      logic [31:0] csr_rdata,        // CSR read data
  output      logic        csr_error,        // CSR access error
  // Timer MMIO port
  input  wire logic        mmio_en,          // MMIO access
  input  wire logic        mmio_wen,         // MMIO write
  input  wire logic [31:0] mmio_addr,        // MMIO address
  input  wire logic [31:0] mmio_wdata,       // MMIO write data
  output      logic [31:0] mmio_rdata,       // MMIO read data
  output      logic        mmio_error,       // MMIO access error
  input  wire logic        instr_ret,        // Instruction retired
  // Interrupts
  input  wire logic        int_nmi,          // Non-maskable line
  input  wire logic        int_external,     // External line
  input  wire logic [3:0]  int_extern_cause, // External cause code
  input  wire logic        int_software,     // Software line
  output      logic        int_mtime,        // Timer pending
  output      logic        int_trap_req,     // Trap request
  output      logic [5:0]  int_trap_cause,   // Trap cause
  input  wire logic        int_trap_ack      // Trap taken
);

  frv_ctr_if ctr_if ();   // Counters to CSR file
  frv_irq_if irq_if ();   // CSR file to interrupt block
  logic      ti_pending;  // Timer compare hit

  assign int_mtime = irq_if.mip_mtip;

  // --------------------------------------------------
  // Instances
  // --------------------------------------------------
  frv_csr_file i_csr_file (
    .g_clk     (g_clk),
    .arst_n    (arst_n),
    .csr_en    (csr_en),
    .csr_wen   (csr_wen),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata),
    .csr_error (csr_error),
    .ctr       (ctr_if.ctr_snk),
    .irq       (irq_if.irq_ctl)
  );

  frv_counters i_counters (
    .g_clk      (g_clk),
    .arst_n     (arst_n),
    .instr_ret  (instr_ret),
    .ctr        (ctr_if.ctr_src),
    .ti_pending (ti_pending),
    .mmio_en    (mmio_en),
    .mmio_wen   (mmio_wen),
    .mmio_addr  (mmio_addr),
    .mmio_wdata (mmio_wdata),
    .mmio_rdata (mmio_rdata),
    .mmio_error (mmio_error)
  );

  frv_interrupt i_interrupt (
    .g_clk          (g_clk),
    .arst_n         (arst_n),
    .irq            (irq_if.irq_src),
    .ti_pending     (ti_pending),
    .nmi_pending    (int_nmi),
    .ex_pending     (int_external),
    .sw_pending     (int_software),
    .ex_cause       (int_extern_cause),
    .int_trap_req   (int_trap_req),
    .int_trap_cause (int_trap_cause),
    .int_trap_ack   (int_trap_ack)
  );

endmodule

`default_nettype wire

//--- tb_frv_machine_ctl.sv
// Machine-control testbench
// Drives the CSR, MMIO, retire and interrupt ports of the top level and
// checks every registered response against a reference model
`default_nettype none

module tb_frv_machine_ctl import frv_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 4000; // About twice the summed test length

  logic        g_clk;
  logic        arst_n;
  logic        csr_en, csr_wen;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata, csr_rdata;
  logic        csr_error;
  logic        mmio_en, mmio_wen;
  logic [31:0] mmio_addr, mmio_wdata, mmio_rdata;
  logic        mmio_error;
  logic        instr_ret;
  logic        int_nmi, int_external, int_software;
  logic [3:0]  int_extern_cause;
  logic        int_mtime, int_trap_req, int_trap_ack;
  logic [5:0]  int_trap_cause;

  // Reference model state
  logic [31:0] m_mstatus, m_mie, m_minh;
  logic [63:0] m_mtimecmp;

  // Access handed to the comparing process
  logic        pend_csr, pend_mmio, pend_chk;
  logic [32:0] pend_exp;                     // {error, data}
  string       pend_name;
  logic [31:0] last_rdata;                   // Data of last access

  integer      seed = 32'h7247;
  int          errors = 0;
  int          cycles = 0;

  frv_machine_ctl frv_machine_ctl_i (.*);

  initial begin
    g_clk = 1'b0;
    forever #20 g_clk = ~g_clk; // 40 ns period
  end

  // ------------------------------------------------
  // Reference model and checks
  // ------------------------------------------------
  function automatic logic [32:0] ref_read(input logic is_mmio, input logic [31:0] addr,
                                           input logic wen);
    logic        err;
    logic [31:0] data;
    err  = 1'b0;
    data = '0;
    if (is_mmio) begin
      case (addr & 32'h0000_0FFF)
        MTIMECMP_LO:        data = m_mtimecmp[31:0];
        MTIMECMP_HI:        data = m_mtimecmp[63:32];
        MTIME_LO, MTIME_HI: data = '0; // Free running so not modelled
        default:            err = 1'b1;
      endcase
      if (addr[31:12] != MMIO_BASE_ADDR[31:12])
        err = 1'b1;
    end else begin
      case (addr[11:0])
        CSR_MSTATUS:       data = m_mstatus;
        CSR_MIE:           data = m_mie;
        CSR_MCOUNTINHIBIT: data = m_minh;
        CSR_MIMPID_ADDR:   data = CSR_MIMPID;
        CSR_MIP, CSR_CYCLE, CSR_CYCLEH, CSR_TIME, CSR_TIMEH,
        CSR_INSTRET, CSR_INSTRETH: data = '0; // Live values
        default:           err = 1'b1;
      endcase
      if (wen && addr[11:10] == 2'b11)
        err = 1'b1; // Read-only by encoding
    end
    return {err, data};
  endfunction

  task automatic fail_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_cause(input string name, input logic [5:0] exp, input logic [5:0] act);
    if (act !== exp)
      fail_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // Outputs settle just after the edge that closes the access
  initial begin : compare
    logic        is_csr, is_mmio, chk;
    logic [32:0] exp;
    string       nm;
    forever begin
      @(posedge g_clk);
      is_csr  = pend_csr;
      is_mmio = pend_mmio;
      chk     = pend_chk;
      exp     = pend_exp;
      nm      = pend_name;
      #1;
      if (arst_n) begin
        check_flag({nm, " csr_error"}, is_csr & exp[32], csr_error);
        check_flag({nm, " mmio_error"}, is_mmio & exp[32], mmio_error);
        if (is_csr)
          last_rdata = csr_rdata;
        else if (is_mmio)
          last_rdata = mmio_rdata;
        if ((is_csr || is_mmio) && chk && !exp[32])
          check_word(nm, exp[31:0], last_rdata);
      end
    end
  end

  always @(posedge g_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
      fail_run("Timeout: the tests did not finish within the cycle limit");
  end

  // ------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------
  task automatic csr_op(input string name, input logic wen, input logic [11:0] addr,
                        input logic [31:0] wdata, input logic chk);
    logic [32:0] exp;
    @(negedge g_clk);
    exp       = ref_read(1'b0, {20'h0, addr}, wen); // Pre-write view
    csr_en    = 1'b1;
    csr_wen   = wen;
    csr_addr  = addr;
    csr_wdata = wdata;
    pend_csr  = 1'b1;
    pend_chk  = chk;
    pend_exp  = exp;
    pend_name = name;
    if (wen && !exp[32]) begin
      case (addr)
        CSR_MSTATUS:       m_mstatus = wdata & 32'h0000_0008;
        CSR_MIE:           m_mie = wdata & 32'h0000_0888;
        CSR_MCOUNTINHIBIT: m_minh = wdata & 32'h0000_0007;
        default:           ;
      endcase
    end
    @(negedge g_clk);
    csr_en   = 1'b0;
    csr_wen  = 1'b0;
    pend_csr = 1'b0;
  endtask

  task automatic mmio_op(input string name, input logic wen, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic chk);
    logic [32:0] exp;
    @(negedge g_clk);
    exp        = ref_read(1'b1, addr, wen);
    mmio_en    = 1'b1;
    mmio_wen   = wen;
    mmio_addr  = addr;
    mmio_wdata = wdata;
    pend_mmio  = 1'b1;
    pend_chk   = chk;
    pend_exp   = exp;
    pend_name  = name;
    if (wen && !exp[32] && addr[3:0] == MTIMECMP_LO[3:0])
      m_mtimecmp[31:0] = wdata;
    if (wen && !exp[32] && addr[3:0] == MTIMECMP_HI[3:0])
      m_mtimecmp[63:32] = wdata;
    @(negedge g_clk);
    mmio_en   = 1'b0;
    mmio_wen  = 1'b0;
    pend_mmio = 1'b0;
  endtask

  task automatic wait_trap(input string name, input logic [5:0] exp);
    int waited;
    int hold;
    waited = 0;
    while (!int_trap_req && waited < 50) begin
      @(negedge g_clk);
      waited++;
    end
    if (!int_trap_req)
      fail_run({"No trap request appeared for ", name});
    hold = {$random(seed)} % 4; // Late acknowledge
    repeat (hold) begin
      check_cause(name, exp, int_trap_cause);
      @(negedge g_clk);
      check_flag({name, " request held"}, 1'b1, int_trap_req);
    end
    check_cause(name, exp, int_trap_cause);
  endtask

  task automatic ack_trap(input string name);
    int_trap_ack = 1'b1;
    @(negedge g_clk);
    int_trap_ack = 1'b0;
    check_flag({name, " request dropped"}, 1'b0, int_trap_req);
  endtask

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] ra;
    logic [5:0]  ex_cause;
    int          n;
    arst_n = 1'b0;
    {csr_en, csr_wen, mmio_en, mmio_wen, instr_ret} = '0;
    {int_nmi, int_external, int_software, int_trap_ack} = '0;
    csr_addr   = '0;
    csr_wdata  = '0;
    mmio_addr  = '0;
    mmio_wdata = '0;
    int_extern_cause = '0;
    {m_mstatus, m_mie, m_minh} = '0;
    m_mtimecmp = '1;
    {pend_csr, pend_mmio, pend_chk} = '0;
    pend_exp   = '0;
    pend_name  = "idle";
    last_rdata = '0;
    repeat (16) @(posedge g_clk);
    @(negedge g_clk);
    arst_n = 1'b1;

    // Random register traffic
    repeat (400) begin
      case ({$random(seed)} % 3)
        0:       ra = CSR_MSTATUS;
        1:       ra = CSR_MIE;
        default: ra = CSR_MCOUNTINHIBIT;
      endcase
      csr_op("reg write", 1'b1, ra, $random(seed), 1'b1);
      csr_op("reg read", 1'b0, ra, '0, 1'b1);
    end
    csr_op("mstatus clear", 1'b1, CSR_MSTATUS, '0, 1'b1);
    csr_op("mie clear", 1'b1, CSR_MIE, '0, 1'b1);
    csr_op("inhibit clear", 1'b1, CSR_MCOUNTINHIBIT, '0, 1'b1);
    csr_op("mimpid read", 1'b0, CSR_MIMPID_ADDR, '0, 1'b1);

    // Access errors
    csr_op("mimpid write", 1'b1, CSR_MIMPID_ADDR, $random(seed), 1'b1);
    csr_op("mimpid after write", 1'b0, CSR_MIMPID_ADDR, '0, 1'b1);
    csr_op("cycle write", 1'b1, CSR_CYCLE, $random(seed), 1'b1);
    csr_op("unknown read", 1'b0, 12'h7C0, '0, 1'b1);
    csr_op("unknown write", 1'b1, 12'h305, '1, 1'b1);
    csr_op("mie after errors", 1'b0, CSR_MIE, '0, 1'b1);
    csr_op("mstatus after errors", 1'b0, CSR_MSTATUS, '0, 1'b1);
    mmio_op("outside window", 1'b1, 32'h0000_2008, $random(seed), 1'b1);
    mmio_op("offset 0x10", 1'b1, MMIO_BASE_ADDR + 32'h10, $random(seed), 1'b1);
    mmio_op("offset 0x2", 1'b0, MMIO_BASE_ADDR + 32'h2, '0, 1'b1);
    mmio_op("mtimecmp lo kept", 1'b0, MMIO_BASE_ADDR + MTIMECMP_LO, '0, 1'b1);

    // Counters
    csr_op("instret base", 1'b0, CSR_INSTRET, '0, 1'b0);
    a = last_rdata;
    n = 5 + {$random(seed)} % 16;
    repeat (n) begin
      @(negedge g_clk);
      instr_ret = 1'b1;
      @(negedge g_clk);
      instr_ret = 1'b0;
    end
    csr_op("instret", 1'b0, CSR_INSTRET, '0, 1'b0);
    check_word("instret count", a + 32'(n), last_rdata);
    a = last_rdata;
    csr_op("inhibit cy ir", 1'b1, CSR_MCOUNTINHIBIT, 32'h5, 1'b1);
    csr_op("cycle held 1", 1'b0, CSR_CYCLE, '0, 1'b0);
    b = last_rdata;
    repeat (4) begin
      @(negedge g_clk);
      instr_ret = 1'b1;
      @(negedge g_clk);
      instr_ret = 1'b0;
    end
    csr_op("cycle held 2", 1'b0, CSR_CYCLE, '0, 1'b0);
    check_word("cycle inhibited", b, last_rdata);
    csr_op("instret held", 1'b0, CSR_INSTRET, '0, 1'b0);
    check_word("instret inhibited", a, last_rdata);
    csr_op("inhibit off", 1'b1, CSR_MCOUNTINHIBIT, '0, 1'b1);
    csr_op("cycle 1", 1'b0, CSR_CYCLE, '0, 1'b0);
    a = last_rdata;
    csr_op("cycle 2", 1'b0, CSR_CYCLE, '0, 1'b0);
    check_flag("cycle increases", 1'b1, last_rdata > a);
    csr_op("time 1", 1'b0, CSR_TIME, '0, 1'b0);
    a = last_rdata;
    csr_op("time 2", 1'b0, CSR_TIME, '0, 1'b0);
    check_flag("time increases", 1'b1, last_rdata > a);

    // Timer
    mmio_op("mtime lo", 1'b0, MMIO_BASE_ADDR + MTIME_LO, '0, 1'b0);
    a = last_rdata;
    mmio_op("mtimecmp lo set", 1'b1, MMIO_BASE_ADDR + MTIMECMP_LO, a + 32'd40, 1'b1);
    mmio_op("mtimecmp hi set", 1'b1, MMIO_BASE_ADDR + MTIMECMP_HI, '0, 1'b1);
    check_flag("int_mtime early", 1'b0, int_mtime);
    n = 0;
    while (!int_mtime && n < 60) begin
      @(negedge g_clk);
      n++;
    end
    if (!int_mtime)
      fail_run("int_mtime did not rise after mtimecmp was reached");
    mmio_op("mtimecmp hi off", 1'b1, MMIO_BASE_ADDR + MTIMECMP_HI, '1, 1'b1);
    @(negedge g_clk);
    check_flag("int_mtime cleared", 1'b0, int_mtime);
    mmio_op("mtimecmp lo off", 1'b1, MMIO_BASE_ADDR + MTIMECMP_LO, '1, 1'b1);

    // Interrupt priority and handshake
    csr_op("mie all", 1'b1, CSR_MIE, 32'h888, 1'b1);
    @(negedge g_clk);
    int_extern_cause = 4'($random(seed));
    ex_cause     = 6'd16 + 6'(int_extern_cause);
    int_external = 1'b1;
    int_software = 1'b1;
    mmio_op("mtimecmp hi zero", 1'b1, MMIO_BASE_ADDR + MTIMECMP_HI, '0, 1'b1);
    mmio_op("mtimecmp lo zero", 1'b1, MMIO_BASE_ADDR + MTIMECMP_LO, '0, 1'b1);
    repeat (10) @(negedge g_clk);
    check_flag("request with mie clear", 1'b0, int_trap_req);
    csr_op("mip read", 1'b0, CSR_MIP, '0, 1'b0);
    check_word("mip pending", 32'h0000_0888, last_rdata);
    csr_op("mstatus mie", 1'b1, CSR_MSTATUS, 32'h8, 1'b1);
    wait_trap("external trap", ex_cause);
    int_external = 1'b0;
    ack_trap("external trap");
    wait_trap("software trap", CAUSE_MSI);
    int_software = 1'b0;
    ack_trap("software trap");
    wait_trap("timer trap", CAUSE_MTI);
    mmio_op("timer off", 1'b1, MMIO_BASE_ADDR + MTIMECMP_HI, '1, 1'b1);
    ack_trap("timer trap");
    mmio_op("timer off lo", 1'b1, MMIO_BASE_ADDR + MTIMECMP_LO, '1, 1'b1);
    repeat (5) @(negedge g_clk);
    check_flag("request after sources cleared", 1'b0, int_trap_req);
    csr_op("mstatus off", 1'b1, CSR_MSTATUS, '0, 1'b1);
    csr_op("mie off", 1'b1, CSR_MIE, '0, 1'b1);
    @(negedge g_clk);
    int_nmi = 1'b1;
    @(negedge g_clk);
    int_nmi = 1'b0;
    wait_trap("nmi trap", CAUSE_NMI);
    ack_trap("nmi trap");
    repeat (5) @(negedge g_clk);

    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
frv_pkg.sv
frv_ifs.sv
frv_counters.sv
frv_interrupt.sv
frv_csr_file.sv
frv_machine_ctl.sv
tb_frv_machine_ctl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the machine-control testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_frv_machine_ctl \
  -f filelist.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1
